/* design/rob_cfg.svh */
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// number of table entries as a power of two
`define ROB_DEPTH 8

// allocation and retire slots per cycle
`define MACHINE_WIDTH 2

// data and address width
`define DATA_W 32

`endif

/* design/core_pkg.sv */
`include "rob_cfg.svh"

package core_pkg;

    // architectural register number
    typedef logic [4:0] reg_t;

    typedef logic [`DATA_W-1:0] word_t;

    // one slot of an allocation group
    typedef struct packed {
        logic       valid;
        reg_t       dst;
        logic       regwrite;
        logic       memwrite;
        logic [1:0] msize;
        word_t      pc;
    } alloc_instr_t;

    // result from the alu pipe
    typedef struct packed {
        logic                          valid;
        logic [$clog2(`ROB_DEPTH)-1:0] rob_addr;
        word_t                         data;
        logic                          exc;
        logic [4:0]                    exc_code;
    } alu_commit_t;

    // data is store data for a store, load result otherwise
    typedef struct packed {
        logic                          valid;
        logic [$clog2(`ROB_DEPTH)-1:0] rob_addr;
        word_t                         data;
        word_t                         addr;
        logic                          exc;
        logic [4:0]                    exc_code;
    } mem_commit_t;

    typedef struct packed {
        logic                          valid;
        reg_t                          dst;
        logic                          regwrite;
        word_t                         data;
        logic [$clog2(`ROB_DEPTH)-1:0] rob_addr;
    } retire_t;

    typedef struct packed {
        logic       wen;
        word_t      addr;
        logic [1:0] size;
        word_t      wd;
    } mem_write_t;

endpackage

/* design/rob_pkg.sv */
`include "rob_cfg.svh"

package rob_pkg;

    // table index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_addr_t;

    // index with wrap bit on top
    typedef logic [$clog2(`ROB_DEPTH):0] rob_ptr_t;

    // occupancy, 0 up to ROB_DEPTH
    typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t;

    // one table entry
    typedef struct packed {
        logic            complete;
        logic            exc;
        logic [4:0]      exc_code;
        core_pkg::reg_t  dst;
        logic            regwrite;
        logic            memwrite;
        logic [1:0]      msize;
        core_pkg::word_t pc;
        // alu result, load result or store data
        core_pkg::word_t data;
        // memory address of a load or store
        core_pkg::word_t addr;
    } rob_entry_t;

    // store drain controller
    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } store_state_t;

endpackage

/* design/rob_ptr_ctrl.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_ptr_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic [1:0]          alloc_count,
    input  logic [1:0]          retire_count,
    output rob_pkg::rob_ptr_t   head,
    output rob_pkg::rob_ptr_t   tail,
    output rob_pkg::rob_count_t count,
    output logic                alloc_ready,
    output logic                empty
);
    import rob_pkg::*;

    rob_count_t free_space;

    // head follows retirement, tail follows allocation
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + rob_ptr_t'(retire_count);
            tail <= tail + rob_ptr_t'(alloc_count);
        end
    end

    // wrap bit keeps the plain difference exact so full reads as ROB_DEPTH
    assign count = rob_count_t'(tail - head);

    assign free_space = rob_count_t'(`ROB_DEPTH) - count;

    // whole group or nothing
    assign alloc_ready = (free_space >= rob_count_t'(`MACHINE_WIDTH));

    assign empty = (count == '0);

endmodule

/* design/rob_table.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_table (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  rob_pkg::rob_ptr_t                             tail,
    input  core_pkg::alloc_instr_t [`MACHINE_WIDTH-1:0]   alloc_in,
    input  core_pkg::alu_commit_t                         alu_commit,
    input  core_pkg::mem_commit_t                         mem_commit,
    input  rob_pkg::rob_addr_t                            read_addr,
    output logic                                          read_ready,
    output core_pkg::word_t                               read_data,
    input  rob_pkg::rob_ptr_t                             head,
    output rob_pkg::rob_entry_t [`MACHINE_WIDTH-1:0]      head_entries
);
    import rob_pkg::*;

    rob_entry_t entries [`ROB_DEPTH];

    rob_addr_t [`MACHINE_WIDTH-1:0] alloc_slot_addr;
    rob_addr_t [`MACHINE_WIDTH-1:0] head_slot_addr;

    // slot i lands at tail + i, head view at head + i
    always_comb begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            alloc_slot_addr[i] = rob_addr_t'(tail + rob_ptr_t'(i));
            head_slot_addr[i] = rob_addr_t'(head + rob_ptr_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // clear the status bits of every entry
            for (int j = 0; j < `ROB_DEPTH; j++) begin
                entries[j].complete <= 1'b0;
                entries[j].exc <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `MACHINE_WIDTH; i++) begin
                if (alloc_in[i].valid) begin
                    entries[alloc_slot_addr[i]].complete <= 1'b0;
                    entries[alloc_slot_addr[i]].exc <= 1'b0;
                    entries[alloc_slot_addr[i]].dst <= alloc_in[i].dst;
                    entries[alloc_slot_addr[i]].regwrite <= alloc_in[i].regwrite;
                    entries[alloc_slot_addr[i]].memwrite <= alloc_in[i].memwrite;
                    entries[alloc_slot_addr[i]].msize <= alloc_in[i].msize;
                    entries[alloc_slot_addr[i]].pc <= alloc_in[i].pc;
                end
            end
            // commits only ever target allocated entries
            if (alu_commit.valid) begin
                entries[alu_commit.rob_addr].complete <= 1'b1;
                entries[alu_commit.rob_addr].data <= alu_commit.data;
                entries[alu_commit.rob_addr].exc <= alu_commit.exc;
                entries[alu_commit.rob_addr].exc_code <= alu_commit.exc_code;
            end
            if (mem_commit.valid) begin
                entries[mem_commit.rob_addr].complete <= 1'b1;
                entries[mem_commit.rob_addr].data <= mem_commit.data;
                entries[mem_commit.rob_addr].addr <= mem_commit.addr;
                entries[mem_commit.rob_addr].exc <= mem_commit.exc;
                entries[mem_commit.rob_addr].exc_code <= mem_commit.exc_code;
            end
        end
    end

    // operand read port
    assign read_ready = entries[read_addr].complete;
    assign read_data = entries[read_addr].data;

    // oldest entries for the retire logic
    always_comb begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            head_entries[i] = entries[head_slot_addr[i]];
        end
    end

endmodule

/* design/retire_select.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module retire_select (
    input  rob_pkg::rob_entry_t [`MACHINE_WIDTH-1:0] head_entries,
    input  rob_pkg::rob_ptr_t                        head,
    input  rob_pkg::rob_count_t                      count,
    input  logic                                     store_idle,
    output core_pkg::retire_t [`MACHINE_WIDTH-1:0]   retire_out,
    output logic [1:0]                               retire_count,
    output logic                                     store_accept,
    output core_pkg::mem_write_t                     store_req,
    output logic                                     exc_valid,
    output logic [4:0]                               exc_code,
    output core_pkg::word_t                          exc_pc
);
    import rob_pkg::*;

    rob_entry_t entry;
    rob_ptr_t   slot_ptr;

    // the first slot that fails ends the in-order group
    always_comb begin
        retire_out = '0;
        retire_count = 2'd0;
        store_accept = 1'b0;
        store_req = '0;
        entry = '0;
        slot_ptr = head;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            entry = head_entries[i];
            slot_ptr = head + rob_ptr_t'(i);
            // past the tail, still pending, or faulted
            if (rob_count_t'(i) >= count || !entry.complete || entry.exc) begin
                break;
            end
            // at most one store, and only into an idle drain
            if (entry.memwrite && (!store_idle || store_accept)) begin
                break;
            end
            retire_out[i].valid = 1'b1;
            retire_out[i].dst = entry.dst;
            retire_out[i].regwrite = entry.regwrite;
            retire_out[i].data = entry.data;
            retire_out[i].rob_addr = rob_addr_t'(slot_ptr);
            if (entry.memwrite) begin
                store_accept = 1'b1;
                store_req.wen = 1'b1;
                store_req.addr = entry.addr;
                store_req.size = entry.msize;
                store_req.wd = entry.data;
            end
            retire_count = retire_count + 2'd1;
        end
    end

    // a faulted head blocks retirement until flush
    assign exc_valid = head_entries[0].complete && head_entries[0].exc;
    assign exc_code = head_entries[0].exc_code;
    assign exc_pc = head_entries[0].pc;

endmodule

/* design/store_drain_fsm.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module store_drain_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 store_accept,
    input  core_pkg::mem_write_t store_req,
    input  logic                 d_data_ok,
    output logic                 store_idle,
    output core_pkg::mem_write_t mem_write
);
    import core_pkg::*;
    import rob_pkg::*;

    store_state_t state;
    store_state_t state_next;

    // the store being written
    mem_write_t pending;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (store_accept) begin
                    state_next = ST_WRITE;
                end
            end
            ST_WRITE: begin
                // memory took the write
                if (d_data_ok) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // flush drops a write still in flight
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && store_accept) begin
            pending <= store_req;
        end
    end

    assign store_idle = (state == ST_IDLE);

    // address, size and data stay put while wen is high
    always_comb begin
        mem_write = pending;
        mem_write.wen = (state == ST_WRITE);
    end

endmodule

/* design/rob_top.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        flush,
    input  core_pkg::alloc_instr_t [`MACHINE_WIDTH-1:0] alloc_in,
    output logic                                        alloc_ready,
    output rob_pkg::rob_addr_t                          alloc_addr,
    input  core_pkg::alu_commit_t                       alu_commit,
    input  core_pkg::mem_commit_t                       mem_commit,
    input  rob_pkg::rob_addr_t                          read_addr,
    output logic                                        read_ready,
    output core_pkg::word_t                             read_data,
    output core_pkg::retire_t [`MACHINE_WIDTH-1:0]      retire_out,
    output logic                                        exc_valid,
    output logic [4:0]                                  exc_code,
    output core_pkg::word_t                             exc_pc,
    output core_pkg::mem_write_t                        mem_write,
    input  logic                                        d_data_ok
);
    import core_pkg::*;
    import rob_pkg::*;

    rob_ptr_t   head;
    rob_ptr_t   tail;
    rob_count_t count;
    logic [1:0] alloc_count;
    logic [1:0] retire_count;
    logic       rob_empty;
    logic       head_exc;
    logic       store_idle;
    logic       store_accept;
    mem_write_t store_req;

    rob_entry_t [`MACHINE_WIDTH-1:0] head_entries;

    // valid slots are packed from slot 0
    always_comb begin
        alloc_count = 2'd0;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            if (alloc_in[i].valid) begin
                alloc_count = alloc_count + 2'd1;
            end
        end
    end

    assign alloc_addr = rob_addr_t'(tail);

    // nothing to report from an empty buffer
    assign exc_valid = head_exc && !rob_empty;

    rob_ptr_ctrl rob_ptr_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .alloc_count  (alloc_count),
        .retire_count (retire_count),
        .head         (head),
        .tail         (tail),
        .count        (count),
        .alloc_ready  (alloc_ready),
        .empty        (rob_empty)
    );

    rob_table rob_table_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .tail         (tail),
        .alloc_in     (alloc_in),
        .alu_commit   (alu_commit),
        .mem_commit   (mem_commit),
        .read_addr    (read_addr),
        .read_ready   (read_ready),
        .read_data    (read_data),
        .head         (head),
        .head_entries (head_entries)
    );

    retire_select retire_select_inst (
        .head_entries (head_entries),
        .head         (head),
        .count        (count),
        .store_idle   (store_idle),
        .retire_out   (retire_out),
        .retire_count (retire_count),
        .store_accept (store_accept),
        .store_req    (store_req),
        .exc_valid    (head_exc),
        .exc_code     (exc_code),
        .exc_pc       (exc_pc)
    );

    store_drain_fsm store_drain_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .store_accept (store_accept),
        .store_req    (store_req),
        .d_data_ok    (d_data_ok),
        .store_idle   (store_idle),
        .mem_write    (mem_write)
    );

endmodule

/* verification/rob_assertions.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_assertions (
    input logic                                        clk,
    input logic                                        reset,
    input logic                                        flush,
    input core_pkg::alloc_instr_t [`MACHINE_WIDTH-1:0] alloc_in,
    input logic                                        alloc_ready,
    input core_pkg::mem_write_t                        mem_write,
    input logic                                        d_data_ok,
    input rob_pkg::rob_count_t                         count
);
    import rob_pkg::*;

    // count of failed assertions
    int   fail_count = 0;
    logic any_alloc;

    always_comb begin
        any_alloc = 1'b0;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            any_alloc = any_alloc | alloc_in[i].valid;
        end
    end

    // a group is only offered when it fits
    alloc_needs_room: assert property (@(posedge clk) disable iff (reset)
        any_alloc |-> alloc_ready)
    else begin
        $error("allocation offered while alloc_ready was low");
        fail_count++;
    end

    // memory sees a steady request until it answers
    write_held: assert property (@(posedge clk) disable iff (reset)
        (mem_write.wen && !d_data_ok && !flush) |=> $stable(mem_write))
    else begin
        $error("mem_write changed before d_data_ok");
        fail_count++;
    end

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= rob_count_t'(`ROB_DEPTH))
    else begin
        $error("occupancy count above table depth");
        fail_count++;
    end

endmodule

bind rob_top rob_assertions rob_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .alloc_in    (alloc_in),
    .alloc_ready (alloc_ready),
    .mem_write   (mem_write),
    .d_data_ok   (d_data_ok),
    .count       (count)
);

/* verification/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_tb;
    import core_pkg::*;
    import rob_pkg::*;

    localparam int CLK_PERIOD = 40;
    // generous bound over the few dozen cycles the tests take
    localparam int MAX_CYCLES = 2000;

    logic                              clk;
    logic                              reset;
    logic                              flush;
    alloc_instr_t [`MACHINE_WIDTH-1:0] alloc_in;
    logic                              alloc_ready;
    rob_addr_t                         alloc_addr;
    alu_commit_t                       alu_commit;
    mem_commit_t                       mem_commit;
    rob_addr_t                         read_addr;
    logic                              read_ready;
    word_t                             read_data;
    retire_t [`MACHINE_WIDTH-1:0]      retire_out;
    logic                              exc_valid;
    logic [4:0]                        exc_code;
    word_t                             exc_pc;
    mem_write_t                        mem_write;
    logic                              d_data_ok;

    // model of allocated entries in age order
    int unsigned model_q[$];
    int unsigned model_tail;
    int unsigned instr_seq;
    reg_t        exp_dst [`ROB_DEPTH];
    logic        exp_regwrite [`ROB_DEPTH];
    logic [1:0]  exp_msize [`ROB_DEPTH];
    word_t       exp_pc [`ROB_DEPTH];
    word_t       exp_data [`ROB_DEPTH];
    word_t       exp_addr [`ROB_DEPTH];

    // writes the memory accepted
    mem_write_t write_log[$];

    int cycles;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    int assert_fails;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (mem_write.wen && d_data_ok) begin
            write_log.push_back(mem_write);
        end
    end

    rob_top rob_top_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .alloc_in    (alloc_in),
        .alloc_ready (alloc_ready),
        .alloc_addr  (alloc_addr),
        .alu_commit  (alu_commit),
        .mem_commit  (mem_commit),
        .read_addr   (read_addr),
        .read_ready  (read_ready),
        .read_data   (read_data),
        .retire_out  (retire_out),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .exc_pc      (exc_pc),
        .mem_write   (mem_write),
        .d_data_ok   (d_data_ok)
    );

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic begin_test;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    // step to the falling edge and idle the commit and alloc inputs
    task automatic next_cycle;
        @(negedge clk);
        alloc_in = '0;
        alu_commit = '0;
        mem_commit = '0;
    endtask

    task automatic alloc_pair(input logic is_store);
        int unsigned a;
        next_cycle();
        if (alloc_ready !== 1'b1) begin
            report_failure("alloc_ready low although a group fits");
        end
        if (alloc_addr !== rob_addr_t'(model_tail)) begin
            report_mismatch("alloc_addr", 32'(alloc_addr), model_tail);
        end
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            a = (model_tail + i) % `ROB_DEPTH;
            alloc_in[i].valid = 1'b1;
            alloc_in[i].dst = reg_t'(instr_seq % 31 + 1);
            alloc_in[i].regwrite = !is_store;
            alloc_in[i].memwrite = is_store;
            alloc_in[i].msize = 2'(i + 1);
            alloc_in[i].pc = 32'h0040_0000 + word_t'(instr_seq * 4);
            exp_dst[a] = alloc_in[i].dst;
            exp_regwrite[a] = !is_store;
            exp_msize[a] = alloc_in[i].msize;
            exp_pc[a] = alloc_in[i].pc;
            model_q.push_back(a);
            instr_seq++;
        end
        model_tail = (model_tail + `MACHINE_WIDTH) % `ROB_DEPTH;
    endtask

    task automatic drive_alu_commit(input int unsigned a, input word_t data,
                                    input logic exc, input logic [4:0] code);
        exp_data[a] = data;
        alu_commit.valid = 1'b1;
        alu_commit.rob_addr = rob_addr_t'(a);
        alu_commit.data = data;
        alu_commit.exc = exc;
        alu_commit.exc_code = code;
    endtask

    task automatic drive_mem_commit(input int unsigned a, input word_t data, input word_t addr);
        exp_data[a] = data;
        exp_addr[a] = addr;
        mem_commit.valid = 1'b1;
        mem_commit.rob_addr = rob_addr_t'(a);
        mem_commit.data = data;
        mem_commit.addr = addr;
    endtask

    task automatic expect_no_retire(input string msg);
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            if (retire_out[i].valid !== 1'b0) begin
                report_failure(msg);
            end
        end
    endtask

    // retire slots must match the oldest model entries in order
    task automatic check_retire;
        int unsigned a;
        logic        prev_valid;
        prev_valid = 1'b1;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            if (retire_out[i].valid === 1'b1) begin
                if (!prev_valid) begin
                    report_failure("retire slot used while a lower slot was idle");
                end
                if (model_q.size() == 0) begin
                    report_failure("retire with no entry outstanding");
                end else begin
                    a = model_q.pop_front();
                    if (retire_out[i].rob_addr !== rob_addr_t'(a)) begin
                        report_mismatch("retire rob_addr", 32'(retire_out[i].rob_addr), a);
                    end
                    if (retire_out[i].dst !== exp_dst[a]) begin
                        report_mismatch("retire dst", 32'(retire_out[i].dst), 32'(exp_dst[a]));
                    end
                    if (retire_out[i].regwrite !== exp_regwrite[a]) begin
                        report_mismatch("retire regwrite", 32'(retire_out[i].regwrite),
                                        32'(exp_regwrite[a]));
                    end
                    if (retire_out[i].data !== exp_data[a]) begin
                        report_mismatch("retire data", retire_out[i].data, exp_data[a]);
                    end
                end
            end
            prev_valid = (retire_out[i].valid === 1'b1);
        end
    endtask

    task automatic drain_retires(input int limit);
        int waited;
        waited = 0;
        while (model_q.size() > 0 && waited < limit) begin
            next_cycle();
            check_retire();
            waited++;
        end
        if (model_q.size() > 0) begin
            report_failure("entries still waiting to retire after the time limit");
        end
    endtask

    task automatic compare_write(input string what, input mem_write_t w, input int unsigned a);
        if (w.addr !== exp_addr[a]) begin
            report_mismatch({what, " addr"}, w.addr, exp_addr[a]);
        end
        if (w.size !== exp_msize[a]) begin
            report_mismatch({what, " size"}, 32'(w.size), 32'(exp_msize[a]));
        end
        if (w.wd !== exp_data[a]) begin
            report_mismatch({what, " wd"}, w.wd, exp_data[a]);
        end
    endtask

    task automatic fill_until_full;
        begin_test();
        // a group goes in only while two entries are free
        while (model_q.size() + `MACHINE_WIDTH <= `ROB_DEPTH) begin
            alloc_pair(1'b0);
        end
        next_cycle();
        if (alloc_ready !== 1'b0) begin
            report_failure("alloc_ready still high with no room for a group");
        end
        if (alloc_addr !== rob_addr_t'(model_tail)) begin
            report_mismatch("alloc_addr", 32'(alloc_addr), model_tail);
        end
        end_test("fill_full");
    endtask

    task automatic retire_reverse_commits;
        int unsigned a;
        begin_test();
        // youngest first, so the head completes last
        for (int k = model_q.size() - 1; k >= 0; k--) begin
            a = model_q[k];
            next_cycle();
            expect_no_retire("retire before the oldest entry completed");
            drive_alu_commit(a, 32'hc0de_0000 + word_t'(a * 32'h111), 1'b0, 5'd0);
        end
        drain_retires(8);
        end_test("ooo_commit");
    endtask

    task automatic read_across_commit;
        int unsigned a;
        begin_test();
        a = model_tail;
        read_addr = rob_addr_t'(a);
        alloc_pair(1'b0);
        next_cycle();
        if (read_ready !== 1'b0) begin
            report_failure("read_ready high before the entry was committed");
        end
        drive_alu_commit(a, 32'h1234_5678 ^ word_t'(a), 1'b0, 5'd0);
        next_cycle();
        if (read_ready !== 1'b1) begin
            report_failure("read_ready low after the entry was committed");
        end
        if (read_data !== exp_data[a]) begin
            report_mismatch("read_data", read_data, exp_data[a]);
        end
        check_retire();
        drive_alu_commit((a + 1) % `ROB_DEPTH, 32'h0bad_cafe, 1'b0, 5'd0);
        drain_retires(4);
        end_test("operand_read");
    endtask

    task automatic drain_back_to_back_stores;
        int unsigned a0;
        int unsigned a1;
        int          waited;
        begin_test();
        write_log.delete();
        a0 = model_tail;
        a1 = (model_tail + 1) % `ROB_DEPTH;
        alloc_pair(1'b1);
        // younger store completes first
        next_cycle();
        drive_mem_commit(a1, 32'hbeef_0001, 32'h1000_0044);
        next_cycle();
        expect_no_retire("store retired before the older store completed");
        drive_mem_commit(a0, 32'hbeef_0000, 32'h1000_0040);
        next_cycle();
        check_retire();
        if (model_q.size() != 1) begin
            report_failure("both stores retired in the same cycle");
        end
        // memory holds off the answer
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            expect_no_retire("second store retired while the first write was pending");
            if (mem_write.wen !== 1'b1) begin
                report_failure("first store not held on the memory port");
            end
            compare_write("mem_write", mem_write, a0);
        end
        d_data_ok = 1'b1;
        next_cycle();
        d_data_ok = 1'b0;
        if (mem_write.wen !== 1'b0) begin
            report_failure("wen still high after d_data_ok");
        end
        check_retire();
        waited = 0;
        next_cycle();
        while (mem_write.wen !== 1'b1 && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (mem_write.wen !== 1'b1) begin
            report_failure("second store never reached the memory port");
        end
        compare_write("mem_write", mem_write, a1);
        d_data_ok = 1'b1;
        next_cycle();
        d_data_ok = 1'b0;
        next_cycle();
        if (write_log.size() != 2) begin
            report_mismatch("accepted write count", write_log.size(), 2);
        end else begin
            compare_write("first write", write_log[0], a0);
            compare_write("second write", write_log[1], a1);
        end
        if (model_q.size() != 0) begin
            report_failure("a store never retired");
        end
        end_test("store_drain");
    endtask

    task automatic flush_faulted_head;
        int unsigned a;
        begin_test();
        a = model_tail;
        read_addr = rob_addr_t'(a);
        alloc_pair(1'b0);
        next_cycle();
        drive_alu_commit(a, 32'hdead_0000, 1'b1, 5'h0c);
        next_cycle();
        drive_alu_commit((a + 1) % `ROB_DEPTH, 32'h0000_0bad, 1'b0, 5'd0);
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            if (exc_valid !== 1'b1) begin
                report_failure("exc_valid low with a faulted entry at the head");
            end
            if (exc_code !== 5'h0c) begin
                report_mismatch("exc_code", 32'(exc_code), 32'h0c);
            end
            if (exc_pc !== exp_pc[a]) begin
                report_mismatch("exc_pc", exc_pc, exp_pc[a]);
            end
            expect_no_retire("retire past a faulted head entry");
        end
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        model_q.delete();
        model_tail = 0;
        if (alloc_ready !== 1'b1) begin
            report_failure("alloc_ready low after flush");
        end
        if (alloc_addr !== rob_addr_t'(0)) begin
            report_mismatch("alloc_addr after flush", 32'(alloc_addr), 0);
        end
        if (exc_valid !== 1'b0 || read_ready !== 1'b0 || mem_write.wen !== 1'b0) begin
            report_failure("buffer not empty after flush");
        end
        expect_no_retire("retire after flush");
        end_test("exc_flush");
    endtask

    initial begin
        cycles = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        model_tail = 0;
        instr_seq = 0;
        reset = 1'b1;
        flush = 1'b0;
        alloc_in = '0;
        alu_commit = '0;
        mem_commit = '0;
        read_addr = '0;
        d_data_ok = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_until_full();
        retire_reverse_commits();
        read_across_commit();
        drain_back_to_back_stores();
        flush_faulted_head();

        assert_fails = rob_top_inst.rob_assertions_inst.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/core_pkg.sv
design/rob_pkg.sv
design/rob_ptr_ctrl.sv
design/rob_table.sv
design/retire_select.sv
design/store_drain_fsm.sv
design/rob_top.sv
verification/rob_assertions.sv
verification/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
